/* verilog.f */
logic/hpsdr_types_pkg.sv
logic/hpsdr_proto_pkg.sv
logic/ds_frame_parser.sv
logic/ds_cmd_register.sv
logic/ds_link_watchdog.sv
logic/cwx_hang_timer.sv
logic/ds_unpacker_top.sv
testbench/ds_unpacker_assertions.sv
testbench/ds_unpacker_tb.sv

/* testbench/ds_unpacker_tb.sv */
// Testbench for the downstream unpacker with a byte level reference model
`timescale 1ns/10ps
`default_nettype none

module ds_unpacker_tb
  import hpsdr_types_pkg::*;
  import hpsdr_proto_pkg::*;
();

  localparam udp_port_t TB_PORT = 16'd1024;
  localparam int unsigned WD_WIDTH = 6;
  localparam int unsigned WD_MAX = (1 << WD_WIDTH) - 1;
  localparam int unsigned HANG = 12;
  localparam int unsigned FRAME_LEN = 8 + 8 * SAMPLES_PER_FRAME;
  // Packet and frame counts of the sequence below rounded up
  localparam int unsigned CYCLE_LIMIT = 2 * (16 * FRAME_LEN + 24 * 20 + 3 * WD_MAX + 2 * HANG);

  // Byte roles seen by the model
  localparam int R_NONE = 0;
  localparam int R_DISC = 1;
  localparam int R_RUNSTOP = 2;
  localparam int R_SEQ0 = 3;
  localparam int R_CTRL = 4;
  localparam int R_D3 = 5;
  localparam int R_D0 = 8;
  localparam int R_L1 = 9;
  localparam int R_R0 = 12;
  localparam int R_I1 = 13;
  localparam int R_I0 = 14;
  localparam int R_Q0 = 16;

  logic clk = 1'b0;
  logic reset;
  udp_port_t eth_port;
  logic eth_valid;
  byte_t eth_data;
  logic eth_unreachable;
  logic watchdog_up;
  logic msec_pulse;
  logic eth_metis_discovery;
  logic run;
  logic wide_spectrum;
  cmd_addr_t cmd_addr;
  cmd_data_t cmd_data;
  logic cmd_cnt;
  logic cmd_resprqst;
  byte_t dseth_tdata;
  logic dsethlr_tvalid;
  logic dsethlr_tlast;
  logic dsethiq_tvalid;
  logic dsethiq_tlast;
  logic dsethiq_tuser;

  logic [31:0] lcg_state = 32'hc639;
  udp_port_t cur_port = TB_PORT;
  int cycle_count = 0;
  int err_count = 0;
  int err_mark = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int iq_seen = 0;

  // Reference model state
  logic m_run = 1'b0;
  logic m_wide = 1'b0;
  logic m_cnt = 1'b0;
  logic m_ptt = 1'b0;
  logic m_resp = 1'b0;
  logic m_cwx_en = 1'b0;
  logic m_cwx = 1'b0;
  logic m_saved = 1'b0;
  logic m_cmd_seen = 1'b0;
  byte_t m_ctrl = '0;
  cmd_data_t m_stage = '0;
  cmd_addr_t m_addr = '0;
  cmd_data_t m_data = '0;
  int m_hang = 0;
  int m_wd = 0;

  always #5 clk = ~clk;

  ds_unpacker_top #(
    .DATA_PORT     (TB_PORT),
    .WATCHDOG_WIDTH(WD_WIDTH),
    .HANG_MSEC     (HANG)
  ) dut_i (
    .clk                (clk),
    .reset              (reset),
    .eth_port           (eth_port),
    .eth_valid          (eth_valid),
    .eth_data           (eth_data),
    .eth_unreachable    (eth_unreachable),
    .watchdog_up        (watchdog_up),
    .msec_pulse         (msec_pulse),
    .eth_metis_discovery(eth_metis_discovery),
    .run                (run),
    .wide_spectrum      (wide_spectrum),
    .cmd_addr           (cmd_addr),
    .cmd_data           (cmd_data),
    .cmd_cnt            (cmd_cnt),
    .cmd_resprqst       (cmd_resprqst),
    .dseth_tdata        (dseth_tdata),
    .dsethlr_tvalid     (dsethlr_tvalid),
    .dsethlr_tlast      (dsethlr_tlast),
    .dsethiq_tvalid     (dsethiq_tvalid),
    .dsethiq_tlast      (dsethiq_tlast),
    .dsethiq_tuser      (dsethiq_tuser)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Cycle limit of %0d reached before the sequence completed", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic byte_t rand_byte();
    logic [31:0] r;
    r = lcg_next();
    return r[23:16];
  endfunction

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cmd(input cmd_addr_t got_addr, input cmd_data_t got_data,
                           input cmd_addr_t exp_addr, input cmd_data_t exp_data);
    if (got_addr !== exp_addr || got_data !== exp_data) begin
      err_count++;
      $display("Fail at %0t: command is %h:%h, expected %h:%h", $time,
               got_addr, got_data, exp_addr, exp_data);
    end
  endtask

  // One clock of drive, falling edge checks and model update
  task automatic run_cycle(input logic valid, input byte_t d, input int role,
                           input logic msec, input logic wd_up, input logic unreach);
    logic iq_en;
    logic expired;
    logic cwx_old;
    @(posedge clk);
    eth_valid       <= valid;
    eth_data        <= d;
    eth_port        <= cur_port;
    msec_pulse      <= msec;
    watchdog_up     <= wd_up;
    eth_unreachable <= unreach;
    @(negedge clk);
    iq_en = m_ptt || (m_hang != 0);
    check_flag("eth_metis_discovery", eth_metis_discovery, role == R_DISC);
    check_flag("dsethlr_tvalid", dsethlr_tvalid, role >= R_L1 && role <= R_R0);
    check_flag("dsethlr_tlast", dsethlr_tlast, role == R_R0);
    check_flag("dsethiq_tvalid", dsethiq_tvalid, iq_en && role >= R_I1 && role <= R_Q0);
    check_flag("dsethiq_tlast", dsethiq_tlast, iq_en && role == R_Q0);
    check_flag("dsethiq_tuser", dsethiq_tuser,
               (role == R_I1) ? m_ptt : ((role == R_I0) ? m_cwx : 1'b0));
    check_flag("run", run, m_run);
    check_flag("wide_spectrum", wide_spectrum, m_wide);
    check_flag("cmd_cnt", cmd_cnt, m_cnt);
    if (valid) check_byte("dseth_tdata", dseth_tdata, d);
    if (m_cmd_seen) begin
      check_cmd(cmd_addr, cmd_data, m_addr, m_data);
      check_flag("cmd_resprqst", cmd_resprqst, m_resp);
    end
    if (dsethiq_tvalid) iq_seen++;

    expired = (m_wd == WD_MAX);
    cwx_old = m_cwx;
    if (!m_run || role == R_SEQ0) m_wd = 0;
    else if (wd_up) m_wd = (m_wd + 1) % (WD_MAX + 1);
    if (unreach || expired) begin
      m_run  = 1'b0;
      m_wide = 1'b0;
    end else if (role == R_RUNSTOP) begin
      m_run  = d[0];
      m_wide = d[1];
    end
    if (role == R_CTRL) m_ctrl = d;
    if (role >= R_D3 && role <= R_D0) m_stage = {m_stage[23:0], d};
    if (role == R_D0) begin
      m_addr     = m_ctrl[6:1];
      m_data     = m_stage;
      m_resp     = m_ctrl[7];
      m_ptt      = m_ctrl[0];
      m_cnt      = ~m_cnt;
      m_cmd_seen = 1'b1;
      if (m_ctrl[6:1] == KEYER_CMD_ADDR) m_cwx_en = m_stage[CWX_ENABLE_BIT];
    end
    if (role == R_I0) m_saved = d[0];
    if (role == R_Q0) m_cwx = m_saved && m_cwx_en && !m_ptt;
    if (cwx_old) m_hang = HANG;
    else if (msec && m_hang != 0) m_hang = m_hang - 1;
  endtask

  task automatic put_byte(input byte_t d, input int role);
    run_cycle(1'b1, d, role, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic idle(input int n);
    repeat (n) run_cycle(1'b0, 8'h00, R_NONE, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic send_header(input byte_t p1, input byte_t op);
    put_byte(PREAMBLE0, R_NONE);
    put_byte(p1, R_NONE);
    put_byte(op, R_NONE);
  endtask

  task automatic send_discovery(input udp_port_t port, input byte_t p1, input logic hit);
    cur_port = port;
    send_header(p1, OP_DISCOVERY);
    put_byte(rand_byte(), hit ? R_DISC : R_NONE);
    cur_port = TB_PORT;
    idle(2);
  endtask

  task automatic send_runstop(input logic [1:0] bits);
    byte_t b;
    b = rand_byte();
    send_header(PREAMBLE1, OP_RUNSTOP);
    put_byte({b[7:2], bits}, R_RUNSTOP);
    idle(2 + b[1:0]);
  endtask

  // kind 0 random command, 1 keyer enabled, 2 keyer disabled; cwx_mode 2 is random
  task automatic send_data(input int frames, input logic ptt, input int cwx_mode,
                           input int kind);
    logic [31:0] r;
    cmd_data_t word;
    byte_t ctrl;
    byte_t b;
    send_header(PREAMBLE1, OP_DATA);
    put_byte(EP_TX, R_NONE);
    repeat (3) put_byte(rand_byte(), R_NONE);
    put_byte(rand_byte(), R_SEQ0);
    r = lcg_next();
    repeat (r[1:0]) begin
      b = rand_byte();
      if (b == SYNC_BYTE) b = 8'h00;
      put_byte(b, R_NONE);
    end
    for (int f = 0; f < frames; f++) begin
      repeat (3) put_byte(SYNC_BYTE, R_NONE);
      r = lcg_next();
      word = lcg_next();
      if (kind == 0) begin
        ctrl = {r[7], r[13:8], ptt};
      end else begin
        ctrl = {r[7], KEYER_CMD_ADDR, ptt};
        word[CWX_ENABLE_BIT] = (kind == 1);
      end
      put_byte(ctrl, R_CTRL);
      for (int i = 0; i < 4; i++) put_byte(word[31 - 8 * i -: 8], R_D3 + i);
      for (int s = 0; s < SAMPLES_PER_FRAME; s++) begin
        for (int k = 0; k < 8; k++) begin
          b = rand_byte();
          if (k == 5 && cwx_mode != 2) b[0] = (cwx_mode == 1);
          put_byte(b, R_L1 + k);
        end
      end
    end
    idle(1 + r[17:16]);
  endtask

  task automatic finish_test(input string name);
    int n;
    n = err_count - err_mark;
    tests_run++;
    if (n != 0) tests_bad++;
    $display("%-12s %0d errors", name, n);
    err_mark = err_count;
  endtask

  initial begin
    logic [31:0] r;
    int total;
    $timeformat(-9, 1, " ns", 0);
    reset           = 1'b1;
    eth_port        = TB_PORT;
    eth_valid       = 1'b0;
    eth_data        = '0;
    eth_unreachable = 1'b0;
    watchdog_up     = 1'b0;
    msec_pulse      = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    send_discovery(TB_PORT, PREAMBLE1, 1'b1);
    send_discovery(udp_port_t'(TB_PORT + 1), PREAMBLE1, 1'b0);
    send_discovery(TB_PORT, 8'hff, 1'b0);
    finish_test("discovery");

    send_runstop(2'b11);
    send_runstop(2'b01);
    send_runstop(2'b10);
    send_runstop(2'b11);
    run_cycle(1'b0, 8'h00, R_NONE, 1'b0, 1'b0, 1'b1);
    idle(2);
    check_flag("run after unreachable", run, 1'b0);
    finish_test("run_stop");

    repeat (3) begin
      r = lcg_next();
      send_data(1 + r[4], r[9], 0, 0);
    end
    finish_test("commands");

    send_data(2, 1'b0, 0, 0);
    finish_test("lr_stream");

    iq_seen = 0;
    send_data(1, 1'b0, 0, 2);
    check_flag("iq without ptt", iq_seen != 0, 1'b0);
    iq_seen = 0;
    send_data(1, 1'b1, 2, 0);
    check_flag("iq with ptt", iq_seen != 0, 1'b1);
    // Key down and then key up with the hang running out
    send_data(1, 1'b0, 1, 1);
    send_data(1, 1'b0, 0, 1);
    repeat (HANG - 1) run_cycle(1'b0, 8'h00, R_NONE, 1'b1, 1'b0, 1'b0);
    iq_seen = 0;
    send_data(1, 1'b0, 0, 1);
    check_flag("iq during hang", iq_seen != 0, 1'b1);
    run_cycle(1'b0, 8'h00, R_NONE, 1'b1, 1'b0, 1'b0);
    iq_seen = 0;
    send_data(1, 1'b0, 0, 1);
    check_flag("iq after hang", iq_seen != 0, 1'b0);
    finish_test("iq_gating");

    send_runstop(2'b01);
    repeat (WD_MAX - 1) run_cycle(1'b0, 8'h00, R_NONE, 1'b0, 1'b1, 1'b0);
    send_data(1, 1'b0, 0, 0);
    repeat (WD_MAX - 1) run_cycle(1'b0, 8'h00, R_NONE, 1'b0, 1'b1, 1'b0);
    idle(2);
    check_flag("run kept by data frame", run, 1'b1);
    run_cycle(1'b0, 8'h00, R_NONE, 1'b0, 1'b1, 1'b0);
    idle(3);
    check_flag("run after expiry", run, 1'b0);
    finish_test("watchdog");

    total = err_count + dut_i.assertions_i.failures;
    $display("Summary: %0d tests, %0d with errors, %0d check errors, %0d assertion failures",
             tests_run, tests_bad, err_count, dut_i.assertions_i.failures);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/ds_unpacker_assertions.sv */
// Concurrent checks on the unpacker strobes, command count and run level
`timescale 1ns/10ps
`default_nettype none

module ds_unpacker_assertions (
  input wire clk,
  input wire reset,
  input wire cmd_commit,
  input wire cmd_cnt,
  input wire run,
  input wire link_expired,
  input wire dsethlr_tvalid,
  input wire dsethlr_tlast,
  input wire dsethiq_tvalid,
  input wire dsethiq_tlast
);

  int unsigned failures = 0;

  // Count only moves on the edge after a commit
  cnt_after_commit: assert property (@(posedge clk) disable iff (reset)
    $changed(cmd_cnt) |-> $past(cmd_commit))
    else begin
      failures++;
      $error("cmd_cnt changed without a preceding commit");
    end

  lr_last_valid: assert property (@(posedge clk) disable iff (reset)
    dsethlr_tlast |-> dsethlr_tvalid)
    else begin
      failures++;
      $error("dsethlr_tlast without dsethlr_tvalid");
    end

  iq_last_valid: assert property (@(posedge clk) disable iff (reset)
    dsethiq_tlast |-> dsethiq_tvalid)
    else begin
      failures++;
      $error("dsethiq_tlast without dsethiq_tvalid");
    end

  // Watchdog expiry stops the radio
  run_stops: assert property (@(posedge clk) disable iff (reset)
    (run && link_expired) |=> !run)
    else begin
      failures++;
      $error("run stayed high after link expiry");
    end

endmodule

bind ds_unpacker_top ds_unpacker_assertions assertions_i (
  .clk           (clk),
  .reset         (reset),
  .cmd_commit    (cmd_commit),
  .cmd_cnt       (cmd_cnt),
  .run           (run),
  .link_expired  (link_expired),
  .dsethlr_tvalid(dsethlr_tvalid),
  .dsethlr_tlast (dsethlr_tlast),
  .dsethiq_tvalid(dsethiq_tvalid),
  .dsethiq_tlast (dsethiq_tlast)
);

`default_nettype wire

/* logic/ds_unpacker_top.sv */
// Downstream protocol 1 unpacker joining the packet FSM and its datapath blocks
`timescale 1ns/10ps
`default_nettype none

module ds_unpacker_top
  import hpsdr_types_pkg::*;
#(
  parameter int unsigned DATA_PORT      = 1024,
  parameter int unsigned WATCHDOG_WIDTH = 10,
  parameter int unsigned HANG_MSEC      = 500
) (
  input  wire        clk,
  input  wire        reset,
  input  udp_port_t  eth_port,
  input  wire        eth_valid,
  input  byte_t      eth_data,
  input  wire        eth_unreachable,
  input  wire        watchdog_up,
  input  wire        msec_pulse,
  output logic       eth_metis_discovery,
  output logic       run,
  output logic       wide_spectrum,
  output cmd_addr_t  cmd_addr,
  output cmd_data_t  cmd_data,
  output logic       cmd_cnt,
  output logic       cmd_resprqst,
  output byte_t      dseth_tdata,
  output logic       dsethlr_tvalid,
  output logic       dsethlr_tlast,
  output logic       dsethiq_tvalid,
  output logic       dsethiq_tlast,
  output logic       dsethiq_tuser
);

  logic cmd_ctrl_load;
  logic cmd_data_shift;
  logic cmd_commit;
  logic frame_start;
  logic cwx_sample;
  logic cwx_update;
  logic cmd_ptt;
  logic cwx_enable;
  logic link_expired;
  logic cwx;
  logic iq_enable;

  // Stream data is the raw payload byte
  assign dseth_tdata = eth_data;

  ds_frame_parser #(
    .DATA_PORT(DATA_PORT)
  ) u_parser (
    .clk                (clk),
    .reset              (reset),
    .eth_port           (eth_port),
    .eth_valid          (eth_valid),
    .eth_data           (eth_data),
    .eth_unreachable    (eth_unreachable),
    .link_expired       (link_expired),
    .cmd_ptt            (cmd_ptt),
    .cwx                (cwx),
    .iq_enable          (iq_enable),
    .eth_metis_discovery(eth_metis_discovery),
    .run                (run),
    .wide_spectrum      (wide_spectrum),
    .cmd_ctrl_load      (cmd_ctrl_load),
    .cmd_data_shift     (cmd_data_shift),
    .cmd_commit         (cmd_commit),
    .frame_start        (frame_start),
    .cwx_sample         (cwx_sample),
    .cwx_update         (cwx_update),
    .dsethlr_tvalid     (dsethlr_tvalid),
    .dsethlr_tlast      (dsethlr_tlast),
    .dsethiq_tvalid     (dsethiq_tvalid),
    .dsethiq_tlast      (dsethiq_tlast),
    .dsethiq_tuser      (dsethiq_tuser)
  );

  ds_cmd_register u_cmd_register (
    .clk           (clk),
    .reset         (reset),
    .eth_data      (eth_data),
    .cmd_ctrl_load (cmd_ctrl_load),
    .cmd_data_shift(cmd_data_shift),
    .cmd_commit    (cmd_commit),
    .cmd_addr      (cmd_addr),
    .cmd_data      (cmd_data),
    .cmd_cnt       (cmd_cnt),
    .cmd_resprqst  (cmd_resprqst),
    .cmd_ptt       (cmd_ptt),
    .cwx_enable    (cwx_enable)
  );

  ds_link_watchdog #(
    .WATCHDOG_WIDTH(WATCHDOG_WIDTH)
  ) u_watchdog (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .frame_start (frame_start),
    .watchdog_up (watchdog_up),
    .link_expired(link_expired)
  );

  cwx_hang_timer #(
    .HANG_MSEC(HANG_MSEC)
  ) u_hang_timer (
    .clk       (clk),
    .reset     (reset),
    .cwx_bit   (eth_data[0]),
    .cwx_sample(cwx_sample),
    .cwx_update(cwx_update),
    .cwx_enable(cwx_enable),
    .cmd_ptt   (cmd_ptt),
    .msec_pulse(msec_pulse),
    .cwx       (cwx),
    .iq_enable (iq_enable)
  );

endmodule

`default_nettype wire

/* logic/cwx_hang_timer.sv */
// CWX keyer sampling with a millisecond hang that holds the I/Q stream open
`timescale 1ns/10ps
`default_nettype none

module cwx_hang_timer
  import hpsdr_types_pkg::*;
#(
  parameter int unsigned HANG_MSEC = 500
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  cwx_bit,
  input  wire  cwx_sample,
  input  wire  cwx_update,
  input  wire  cwx_enable,
  input  wire  cmd_ptt,
  input  wire  msec_pulse,
  output logic cwx,
  output logic iq_enable
);

  logic      cwx_saved;
  hang_cnt_t hang_cnt;

  always_ff @(posedge clk) begin
    if (cwx_sample) cwx_saved <= cwx_bit;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cwx      <= 1'b0;
      hang_cnt <= '0;
    end else begin
      // Key is ignored while the host itself is transmitting
      if (cwx_update) cwx <= cwx_saved & cwx_enable & ~cmd_ptt;
      if (cwx) begin
        hang_cnt <= hang_cnt_t'(HANG_MSEC);
      end else if (msec_pulse && hang_cnt != '0) begin
        hang_cnt <= hang_cnt - 1'b1;
      end
    end
  end

  assign iq_enable = cmd_ptt | (hang_cnt != '0);

endmodule

`default_nettype wire

/* logic/ds_link_watchdog.sv */
// Watchdog counting upstream packets sent since the last received data frame
`timescale 1ns/10ps
`default_nettype none

module ds_link_watchdog #(
  parameter int unsigned WATCHDOG_WIDTH = 10
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  run,
  input  wire  frame_start,
  input  wire  watchdog_up,
  output logic link_expired
);

  logic [WATCHDOG_WIDTH-1:0] up_cnt;

  always_ff @(posedge clk) begin
    if (reset || !run || frame_start) begin
      up_cnt <= '0;
    end else if (watchdog_up) begin
      up_cnt <= up_cnt + 1'b1;
    end
  end

  // Expires once the count reaches all ones
  assign link_expired = &up_cnt;

endmodule

`default_nettype wire

/* logic/ds_cmd_register.sv */
// Command word register that stages control and data bytes and publishes them
`timescale 1ns/10ps
`default_nettype none

module ds_cmd_register
  import hpsdr_types_pkg::*;
  import hpsdr_proto_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  byte_t      eth_data,
  input  wire        cmd_ctrl_load,
  input  wire        cmd_data_shift,
  input  wire        cmd_commit,
  output cmd_addr_t  cmd_addr,
  output cmd_data_t  cmd_data,
  output logic       cmd_cnt,
  output logic       cmd_resprqst,
  output logic       cmd_ptt,
  output logic       cwx_enable
);

  cmd_addr_t addr_stage;
  cmd_data_t data_stage;
  cmd_data_t data_next;
  logic      resprqst_stage;
  logic      ptt_stage;

  // Last data byte joins the staged bytes at commit
  assign data_next = {data_stage[23:0], eth_data};

  always_ff @(posedge clk) begin
    if (cmd_ctrl_load) begin
      resprqst_stage <= eth_data[7];
      addr_stage     <= eth_data[6:1];
      ptt_stage      <= eth_data[0];
    end
    if (cmd_data_shift) data_stage <= data_next;
    if (cmd_commit) begin
      cmd_addr <= addr_stage;
      cmd_data <= data_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_cnt      <= 1'b0;
      cmd_resprqst <= 1'b0;
      cmd_ptt      <= 1'b0;
      cwx_enable   <= 1'b0;
    end else if (cmd_commit) begin
      cmd_cnt      <= ~cmd_cnt;
      cmd_resprqst <= resprqst_stage;
      cmd_ptt      <= ptt_stage;
      if (addr_stage == KEYER_CMD_ADDR) cwx_enable <= data_next[CWX_ENABLE_BIT];
    end
  end

endmodule

`default_nettype wire

/* logic/ds_frame_parser.sv */
// Downstream packet FSM that decodes protocol 1 packets and strobes the datapath
`timescale 1ns/10ps
`default_nettype none

module ds_frame_parser
  import hpsdr_types_pkg::*;
  import hpsdr_proto_pkg::*;
#(
  parameter int unsigned DATA_PORT = 1024
) (
  input  wire        clk,
  input  wire        reset,
  input  udp_port_t  eth_port,
  input  wire        eth_valid,
  input  byte_t      eth_data,
  input  wire        eth_unreachable,
  input  wire        link_expired,
  input  wire        cmd_ptt,
  input  wire        cwx,
  input  wire        iq_enable,
  output logic       eth_metis_discovery,
  output logic       run,
  output logic       wide_spectrum,
  output logic       cmd_ctrl_load,
  output logic       cmd_data_shift,
  output logic       cmd_commit,
  output logic       frame_start,
  output logic       cwx_sample,
  output logic       cwx_update,
  output logic       dsethlr_tvalid,
  output logic       dsethlr_tlast,
  output logic       dsethiq_tvalid,
  output logic       dsethiq_tlast,
  output logic       dsethiq_tuser
);

  typedef enum logic [4:0] {
    ST_IDLE, ST_PREAMBLE, ST_DECODE, ST_RUNSTOP, ST_DISCOVERY, ST_ENDPOINT,
    ST_SEQ3, ST_SEQ2, ST_SEQ1, ST_SEQ0,
    ST_SYNC2, ST_SYNC1, ST_SYNC0,
    ST_CMD_CTRL, ST_CMD_DATA3, ST_CMD_DATA2, ST_CMD_DATA1, ST_CMD_DATA0,
    ST_PUSH_L1, ST_PUSH_L0, ST_PUSH_R1, ST_PUSH_R0,
    ST_PUSH_I1, ST_PUSH_I0, ST_PUSH_Q1, ST_PUSH_Q0,
    ST_DROP
  } state_t;

  state_t      state;
  state_t      state_next;
  sample_cnt_t sample_cnt;
  sample_cnt_t sample_cnt_next;
  logic        run_next;
  logic        wide_spectrum_next;
  logic        port_match;

  assign port_match = (eth_port == udp_port_t'(DATA_PORT));

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= ST_IDLE;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
      sample_cnt    <= '0;
    end else begin
      sample_cnt <= sample_cnt_next;
      // Link loss stops the radio as well as the packet
      if (eth_unreachable || link_expired) begin
        state         <= ST_IDLE;
        run           <= 1'b0;
        wide_spectrum <= 1'b0;
      end else if (!eth_valid) begin
        state <= ST_IDLE;
      end else begin
        state         <= state_next;
        run           <= run_next;
        wide_spectrum <= wide_spectrum_next;
      end
    end
  end

  always_comb begin
    state_next          = ST_DROP;
    run_next            = run;
    wide_spectrum_next  = wide_spectrum;
    sample_cnt_next     = sample_cnt;
    eth_metis_discovery = 1'b0;
    cmd_ctrl_load       = 1'b0;
    cmd_data_shift      = 1'b0;
    cmd_commit          = 1'b0;
    frame_start         = 1'b0;
    cwx_sample          = 1'b0;
    cwx_update          = 1'b0;
    dsethlr_tvalid      = 1'b0;
    dsethlr_tlast       = 1'b0;
    dsethiq_tvalid      = 1'b0;
    dsethiq_tlast       = 1'b0;
    dsethiq_tuser       = 1'b0;

    // Strobes only fire on a real byte
    if (eth_valid) begin
      case (state)
        ST_IDLE: begin
          if (eth_data == PREAMBLE0 && port_match) state_next = ST_PREAMBLE;
        end
        ST_PREAMBLE: begin
          if (eth_data == PREAMBLE1 && port_match) state_next = ST_DECODE;
        end
        ST_DECODE: begin
          // Flash opcodes fall through to drop
          case (eth_data)
            OP_DATA:      state_next = ST_ENDPOINT;
            OP_DISCOVERY: state_next = ST_DISCOVERY;
            OP_RUNSTOP:   state_next = ST_RUNSTOP;
            default:      state_next = ST_DROP;
          endcase
        end
        ST_RUNSTOP: begin
          run_next           = eth_data[0];
          wide_spectrum_next = eth_data[1];
        end
        ST_DISCOVERY: eth_metis_discovery = 1'b1;
        ST_ENDPOINT: begin
          if (eth_data == EP_TX) state_next = ST_SEQ3;
        end
        ST_SEQ3: state_next = ST_SEQ2;
        ST_SEQ2: state_next = ST_SEQ1;
        ST_SEQ1: state_next = ST_SEQ0;
        ST_SEQ0: begin
          frame_start = 1'b1;
          state_next  = ST_SYNC2;
        end
        // Hunt for three sync bytes in a row
        ST_SYNC2: begin
          sample_cnt_next = '0;
          state_next = (eth_data == SYNC_BYTE) ? ST_SYNC1 : ST_SYNC2;
        end
        ST_SYNC1: begin
          sample_cnt_next = '0;
          state_next = (eth_data == SYNC_BYTE) ? ST_SYNC0 : ST_SYNC2;
        end
        ST_SYNC0: begin
          sample_cnt_next = '0;
          state_next = (eth_data == SYNC_BYTE) ? ST_CMD_CTRL : ST_SYNC2;
        end
        ST_CMD_CTRL: begin
          cmd_ctrl_load = 1'b1;
          state_next    = ST_CMD_DATA3;
        end
        ST_CMD_DATA3: begin
          cmd_data_shift = 1'b1;
          state_next     = ST_CMD_DATA2;
        end
        ST_CMD_DATA2: begin
          cmd_data_shift = 1'b1;
          state_next     = ST_CMD_DATA1;
        end
        ST_CMD_DATA1: begin
          cmd_data_shift = 1'b1;
          state_next     = ST_CMD_DATA0;
        end
        ST_CMD_DATA0: begin
          cmd_data_shift = 1'b1;
          cmd_commit     = 1'b1;
          state_next     = ST_PUSH_L1;
        end
        ST_PUSH_L1: begin
          dsethlr_tvalid = 1'b1;
          state_next     = ST_PUSH_L0;
        end
        ST_PUSH_L0: begin
          dsethlr_tvalid = 1'b1;
          state_next     = ST_PUSH_R1;
        end
        ST_PUSH_R1: begin
          dsethlr_tvalid = 1'b1;
          state_next     = ST_PUSH_R0;
        end
        ST_PUSH_R0: begin
          dsethlr_tvalid = 1'b1;
          dsethlr_tlast  = 1'b1;
          state_next     = ST_PUSH_I1;
        end
        ST_PUSH_I1: begin
          dsethiq_tvalid = iq_enable;
          dsethiq_tuser  = cmd_ptt;
          state_next     = ST_PUSH_I0;
        end
        ST_PUSH_I0: begin
          dsethiq_tvalid = iq_enable;
          dsethiq_tuser  = cwx;
          cwx_sample     = 1'b1;
          state_next     = ST_PUSH_Q1;
        end
        ST_PUSH_Q1: begin
          dsethiq_tvalid = iq_enable;
          state_next     = ST_PUSH_Q0;
        end
        ST_PUSH_Q0: begin
          dsethiq_tvalid = iq_enable;
          dsethiq_tlast  = iq_enable;
          cwx_update     = 1'b1;
          // Last sample of the frame goes back to sync
          if (sample_cnt == sample_cnt_t'(SAMPLES_PER_FRAME - 1)) begin
            state_next = ST_SYNC2;
          end else begin
            sample_cnt_next = sample_cnt + 1'b1;
            state_next      = ST_PUSH_L1;
          end
        end
        default: state_next = ST_DROP;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/hpsdr_proto_pkg.sv */
// OpenHPSDR protocol 1 constants for the downstream packet format
`default_nettype none

package hpsdr_proto_pkg;

  // Packet start
  parameter logic [7:0] PREAMBLE0 = 8'hef;
  parameter logic [7:0] PREAMBLE1 = 8'hfe;

  // Opcodes following the preamble
  parameter logic [7:0] OP_DATA      = 8'h01;
  parameter logic [7:0] OP_DISCOVERY = 8'h02;
  parameter logic [7:0] OP_RUNSTOP   = 8'h04;

  // Only the transmit endpoint is decoded
  parameter logic [7:0] EP_TX = 8'h02;

  // Frame framing
  parameter logic [7:0] SYNC_BYTE = 8'h7f;
  parameter int unsigned SAMPLES_PER_FRAME = 63;

  // Keyer control register and its CWX enable bit
  parameter logic [5:0] KEYER_CMD_ADDR = 6'h0f;
  parameter int unsigned CWX_ENABLE_BIT = 24;

endpackage

`default_nettype wire

/* logic/hpsdr_types_pkg.sv */
// Shared vector types for the downstream unpacker datapath
`default_nettype none

package hpsdr_types_pkg;

  // Payload byte and UDP port
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] udp_port_t;

  // Command word fields
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // Samples pushed so far in the current frame
  typedef logic [5:0]  sample_cnt_t;

  // Milliseconds left in the CWX hang
  typedef logic [8:0]  hang_cnt_t;

endpackage

`default_nettype wire
